/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
	input logic clk,
	input logic rst,
	input cpuPkg::opcode_e op,
	input logic flagWe,
	input cpuPkg::word_t in1,
	input cpuPkg::word_t in2,
	output cpuPkg::word_t result,
	output cpuPkg::flags_t flags
);
	import cpuPkg::*;

	logic [DataWidth:0] sumWide;
	logic [DataWidth:0] diffWide;
	logic [DataWidth:0] shlWide;
	logic [DataWidth:0] shrWide;
	logic [3:0] shamt;
	logic carry;

	assign shamt = in2[3:0];

	// One spare bit catches carry, borrow or the shifted-out bit
	assign sumWide = {1'b0, in1} + {1'b0, in2};
	assign diffWide = {1'b0, in1} - {1'b0, in2};
	assign shlWide = {1'b0, in1} << shamt;
	assign shrWide = {in1, 1'b0} >> shamt;

	always_comb begin
		result = in1;
		carry = 1'b0;
		case (op)
			ADD: begin
				result = sumWide[DataWidth-1:0];
				carry = sumWide[DataWidth];
			end
			SUB: begin
				result = diffWide[DataWidth-1:0];
				carry = diffWide[DataWidth];
			end
			AND: result = in1 & in2;
			OR: result = in1 | in2;
			XOR: result = in1 ^ in2;
			SHL: begin
				result = shlWide[DataWidth-1:0];
				carry = shlWide[DataWidth];
			end
			SHR: begin
				result = shrWide[DataWidth:1];
				carry = shrWide[0];
			end
			MOV: result = in2;
			default: begin
				result = in1;
				carry = 1'b0;
			end
		endcase
	end

	// Flags only move on arithmetic, logic and shift ops
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			flags <= '0;
		end
		else if (flagWe) begin
			flags.c <= carry;
			flags.z <= (result == '0);
		end
	end

endmodule

/* rtl/cpuPkg.sv */
package cpuPkg;

	// Machine sizes
	localparam int DataWidth = 16;
	localparam int RegCount = 16;
	localparam int DataDepth = 128;

	// Derived sizes
	localparam int RegIdxWidth = $clog2(RegCount);
	localparam int DataAddrWidth = $clog2(DataDepth);
	localparam int ImmWidth = 8;

	typedef logic [DataWidth-1:0] word_t;
	typedef logic [RegIdxWidth-1:0] regIdx_t;

	// Opcode encoding follows the order of the instruction set table
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		SHL = 4'h5,
		SHR = 4'h6,
		MOV = 4'h7,
		LDI = 4'h8,
		LD  = 4'h9,
		ST  = 4'hA,
		JMP = 4'hB,
		JZ  = 4'hC,
		JC  = 4'hD,
		JR  = 4'hE,
		NOP = 4'hF
	} opcode_e;

	// Immediate is {rs, lo}
	typedef struct packed {
		opcode_e opcode;
		regIdx_t rd;
		regIdx_t rs;
		logic [3:0] lo;
	} instr_t;

	typedef enum logic [1:0] {
		WbAlu,
		WbImm,
		WbMem
	} wbSel_e;

	typedef enum logic [1:0] {
		AddrRd,
		AddrRs,
		AddrImm
	} addrSel_e;

	typedef enum logic [1:0] {
		PcInc,
		PcImm,
		PcReg
	} pcSel_e;

	typedef struct packed {
		opcode_e aluOp;
		logic regWe;
		wbSel_e wbSel;
		addrSel_e addrSel;
		logic memWe;
		pcSel_e pcSel;
		logic flagWe;
		word_t imm;
	} ctrl_t;

	typedef struct packed {
		logic c;
		logic z;
	} flags_t;

	typedef struct packed {
		logic valid;
		word_t addr;
		word_t data;
	} store_t;

endpackage

/* rtl/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
	input logic clk,
	input logic rst,
	input cpuPkg::word_t instrData,
	output cpuPkg::word_t instrAddr,
	output cpuPkg::store_t storeEvent
);
	import cpuPkg::*;

	instr_t instr;
	ctrl_t ctrl;
	flags_t flags;
	word_t rdData;
	word_t rsData;
	word_t aluResult;
	word_t wbData;

	// Register indices come straight from the fetched word
	assign instr = instr_t'(instrData);

	instrDecoder u_decoder (
		.instrData(instrData),
		.flags(flags),
		.ctrl(ctrl)
	);

	regFile u_regFile (
		.clk(clk),
		.rst(rst),
		.we(ctrl.regWe),
		.rdIdx(instr.rd),
		.rsIdx(instr.rs),
		.wbData(wbData),
		.rdData(rdData),
		.rsData(rsData)
	);

	alu u_alu (
		.clk(clk),
		.rst(rst),
		.op(ctrl.aluOp),
		.flagWe(ctrl.flagWe),
		.in1(rdData),
		.in2(rsData),
		.result(aluResult),
		.flags(flags)
	);

	// JR takes its target from rs
	pcUnit u_pcUnit (
		.clk(clk),
		.rst(rst),
		.pcSel(ctrl.pcSel),
		.imm(ctrl.imm),
		.regTarget(rsData),
		.instrAddr(instrAddr)
	);

	loadStoreUnit u_loadStore (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.rdData(rdData),
		.rsData(rsData),
		.aluResult(aluResult),
		.wbData(wbData),
		.storeEvent(storeEvent)
	);

endmodule

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
	input cpuPkg::word_t instrData,
	input cpuPkg::flags_t flags,
	output cpuPkg::ctrl_t ctrl
);
	import cpuPkg::*;

	instr_t instr;
	word_t immExt;

	assign instr = instr_t'(instrData);

	// 8-bit immediate, zero-extended
	assign immExt = {{(DataWidth-ImmWidth){1'b0}}, instr.rs, instr.lo};

	always_comb begin
		// Defaults describe a NOP
		ctrl.aluOp = instr.opcode;
		ctrl.regWe = 1'b0;
		ctrl.wbSel = WbAlu;
		ctrl.addrSel = AddrRd;
		ctrl.memWe = 1'b0;
		ctrl.pcSel = PcInc;
		ctrl.flagWe = 1'b0;
		ctrl.imm = immExt;

		case (instr.opcode)
			ADD, SUB: begin
				ctrl.regWe = 1'b1;
				ctrl.flagWe = 1'b1;
			end
			AND, OR, XOR: begin
				ctrl.regWe = 1'b1;
				ctrl.flagWe = 1'b1;
			end
			SHL, SHR: begin
				ctrl.regWe = 1'b1;
				ctrl.flagWe = 1'b1;
			end
			// Register copy keeps the old flags
			MOV: begin
				ctrl.regWe = 1'b1;
			end
			LDI: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = WbImm;
			end
			LD: begin
				ctrl.regWe = 1'b1;
				ctrl.wbSel = WbMem;
				ctrl.addrSel = AddrRs;
			end
			// Address in rd, data from rs
			ST: begin
				ctrl.memWe = 1'b1;
				ctrl.addrSel = AddrRd;
			end
			JMP: begin
				ctrl.pcSel = PcImm;
			end
			// Conditional jumps resolved here against current flags
			JZ: begin
				ctrl.pcSel = flags.z ? PcImm : PcInc;
			end
			JC: begin
				ctrl.pcSel = flags.c ? PcImm : PcInc;
			end
			JR: begin
				ctrl.pcSel = PcReg;
			end
			NOP: begin
				ctrl.pcSel = PcInc;
			end
			default: begin
				ctrl.regWe = 1'b0;
				ctrl.memWe = 1'b0;
				ctrl.flagWe = 1'b0;
			end
		endcase
	end

endmodule

/* rtl/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit (
	input logic clk,
	input logic rst,
	input cpuPkg::ctrl_t ctrl,
	input cpuPkg::word_t rdData,
	input cpuPkg::word_t rsData,
	input cpuPkg::word_t aluResult,
	output cpuPkg::word_t wbData,
	output cpuPkg::store_t storeEvent
);
	import cpuPkg::*;

	word_t ram [DataDepth];
	word_t memAddr;
	word_t ramData;
	logic [DataAddrWidth-1:0] ramIdx;

	always_comb begin
		case (ctrl.addrSel)
			AddrRs: memAddr = rsData;
			AddrImm: memAddr = ctrl.imm;
			default: memAddr = rdData;
		endcase
	end

	// Upper address bits are ignored
	assign ramIdx = memAddr[DataAddrWidth-1:0];

	// Asynchronous read, so a load right after a store sees the new word
	assign ramData = ram[ramIdx];

	// No writes while the core is held in reset
	always_ff @(posedge clk) begin
		if (!rst && ctrl.memWe) begin
			ram[ramIdx] <= rsData;
		end
	end

	always_comb begin
		case (ctrl.wbSel)
			WbImm: wbData = ctrl.imm;
			WbMem: wbData = ramData;
			default: wbData = aluResult;
		endcase
	end

	// Visible for the whole cycle the store commits in
	assign storeEvent.valid = ctrl.memWe && !rst;
	assign storeEvent.addr = memAddr;
	assign storeEvent.data = rsData;

endmodule

/* rtl/pcUnit.sv */
`timescale 1ns/1ps

module pcUnit (
	input logic clk,
	input logic rst,
	input cpuPkg::pcSel_e pcSel,
	input cpuPkg::word_t imm,
	input cpuPkg::word_t regTarget,
	output cpuPkg::word_t instrAddr
);
	import cpuPkg::*;

	word_t nextPc;

	always_comb begin
		case (pcSel)
			// Absolute target from the instruction
			PcImm: nextPc = imm;
			// Register-indirect jump
			PcReg: nextPc = regTarget;
			default: nextPc = instrAddr + word_t'(1);
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			instrAddr <= '0;
		end
		else begin
			instrAddr <= nextPc;
		end
	end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rst,
	input logic we,
	input cpuPkg::regIdx_t rdIdx,
	input cpuPkg::regIdx_t rsIdx,
	input cpuPkg::word_t wbData,
	output cpuPkg::word_t rdData,
	output cpuPkg::word_t rsData
);
	import cpuPkg::*;

	word_t regs [RegCount];

	// Both read ports are combinational
	assign rdData = regs[rdIdx];
	assign rsData = regs[rsIdx];

	// Single write port, always targets rd
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end
		else if (we) begin
			regs[rdIdx] <= wbData;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Compile with Verilator and run; exit status carries the verdict
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
	--top-module cpuTop_tb \
	-Mdir obj_dir \
	-o cpuTop_sim \
	-f vlog.f
./obj_dir/cpuTop_sim

/* verification/cpuTop_properties.sv */
`timescale 1ns/1ps

module cpuTop_properties (
	input logic clk,
	input logic rst,
	input cpuPkg::word_t instrAddr,
	input cpuPkg::store_t storeEvent,
	input cpuPkg::ctrl_t ctrl
);

	// Fetch parked at 0 while reset is held
	pcInReset: assert property (@(posedge clk) rst |-> instrAddr == '0)
		else $error("instrAddr not 0 during reset");

	noStoreInReset: assert property (@(posedge clk) rst |-> !storeEvent.valid)
		else $error("storeEvent.valid high during reset");

	// ST writes memory only, never a register
	storeOrWrite: assert property (@(posedge clk) disable iff (rst) !(ctrl.memWe && ctrl.regWe))
		else $error("store and register write in the same cycle");

endmodule

bind cpuTop cpuTop_properties u_props (
	.clk(clk),
	.rst(rst),
	.instrAddr(instrAddr),
	.storeEvent(storeEvent),
	.ctrl(ctrl)
);

/* verification/cpuTop_tb.sv */
`timescale 1ns/1ps

module cpuTop_tb;
	import cpuPkg::*;

	localparam int FixedRows = 10;
	localparam int RandomRows = 6;
	localparam int NumRows = FixedRows + RandomRows;
	localparam int CycleLimit = NumRows * (16 + 20) + 50;
	localparam store_t NoStore = '0;

	typedef struct {
		opcode_e op;
		word_t a;
		word_t b;
		word_t res;
		flags_t f;
	} row_t;

	logic clk;
	logic rst;
	word_t instrData;
	word_t instrAddr;
	store_t storeEvent;

	word_t rom [64];
	row_t rows [NumRows];
	int cycles = 0;

	cpuTop u_dut (
		.clk(clk),
		.rst(rst),
		.instrData(instrData),
		.instrAddr(instrAddr),
		.storeEvent(storeEvent)
	);

	// Program ROM answers in the same cycle
	assign instrData = rom[instrAddr[5:0]];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "Stopped at first error");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			abortRun($sformatf("Timeout: no verdict after %0d cycles", cycles));
		end
	end

	// Expected result and flags from the instruction set rules
	function automatic row_t makeRow(input opcode_e op, input word_t a, input word_t b);
		row_t rw;
		int n;
		n = int'(b[3:0]);
		rw.op = op;
		rw.a = a;
		rw.b = b;
		rw.f.c = 1'b0;
		case (op)
			ADD: begin
				rw.res = a + b;
				rw.f.c = (int'(a) + int'(b)) > 65535;
			end
			SUB: begin
				rw.res = a - b;
				rw.f.c = (a < b);
			end
			AND: rw.res = a & b;
			OR: rw.res = a | b;
			XOR: rw.res = a ^ b;
			SHL: begin
				rw.res = a << n;
				if (n > 0)
					rw.f.c = a[16 - n];
			end
			SHR: begin
				rw.res = a >> n;
				if (n > 0)
					rw.f.c = a[n - 1];
			end
			default: rw.res = b;
		endcase
		rw.f.z = (rw.res == 16'h0000);
		// MOV leaves the flags of the opening SUB r0,r0
		if (op == MOV) begin
			rw.f.c = 1'b0;
			rw.f.z = 1'b1;
		end
		return rw;
	endfunction

	function automatic word_t encReg(input opcode_e op, input regIdx_t rd, input regIdx_t rs);
		return {op, rd, rs, 4'h0};
	endfunction

	function automatic word_t encImm(input opcode_e op, input regIdx_t rd, input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	task automatic checkAddr(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			abortRun($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic checkStore(input string name, input store_t got, input store_t exp);
		if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
			abortRun($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic checkFlagPath(input flags_t got, input flags_t exp);
		if (got !== exp) begin
			abortRun($sformatf("Mismatch at %0t: branch flags got c=%b z=%b expected c=%b z=%b",
				$time, got.c, got.z, exp.c, exp.z));
		end
	endtask

	task automatic fillNop();
		for (int i = 0; i < 64; i++) begin
			rom[i] = encReg(NOP, 4'd0, 4'd0);
		end
	endtask

	task automatic loadProgram(input row_t rw);
		fillNop();
		rom[0] = encReg(SUB, 4'd0, 4'd0);
		rom[1] = encImm(LDI, 4'd1, rw.a[7:0]);
		rom[2] = encImm(LDI, 4'd2, rw.b[7:0]);
		rom[3] = encReg(rw.op, 4'd1, 4'd2);
		rom[4] = encImm(LDI, 4'd3, 8'h10);
		rom[5] = encReg(ST, 4'd3, 4'd1);
		rom[6] = encImm(JZ, 4'd0, 8'd9);
		rom[9] = encImm(JC, 4'd0, 8'd12);
		rom[12] = encReg(LD, 4'd4, 4'd3);
		rom[13] = encImm(LDI, 4'd5, 8'h20);
		rom[14] = encReg(ST, 4'd5, 4'd4);
		rom[15] = encImm(LDI, 4'd6, 8'd18);
		rom[16] = encReg(JR, 4'd0, 4'd6);
		rom[18] = encImm(JMP, 4'd0, 8'd18);
	endtask

	// Reset lands wherever the previous program stopped
	task automatic resetCore(input int r);
		@(negedge clk);
		rst = 1'b1;
		loadProgram(rows[r]);
		repeat (16) begin
			@(negedge clk);
			checkAddr("instrAddr in reset", instrAddr, 16'h0000);
			checkStore("storeEvent in reset", storeEvent, NoStore);
		end
		rst = 1'b0;
	endtask

	task automatic stepAt(input word_t pc, input store_t st);
		checkAddr("instrAddr", instrAddr, pc);
		checkStore("storeEvent", storeEvent, st);
		@(negedge clk);
	endtask

	task automatic runRow(input int r);
		flags_t seen;
		store_t firstStore;
		store_t secondStore;
		resetCore(r);
		firstStore = {1'b1, 16'h0010, rows[r].res};
		secondStore = {1'b1, 16'h0020, rows[r].res};
		for (int pc = 0; pc < 5; pc++) begin
			stepAt(16'(pc), NoStore);
		end
		stepAt(16'd5, firstStore);
		stepAt(16'd6, NoStore);
		// Address after each probe tells which way it went
		seen.z = (instrAddr == 16'd9);
		if (!seen.z) begin
			stepAt(16'd7, NoStore);
			stepAt(16'd8, NoStore);
		end
		stepAt(16'd9, NoStore);
		seen.c = (instrAddr == 16'd12);
		if (!seen.c) begin
			stepAt(16'd10, NoStore);
			stepAt(16'd11, NoStore);
		end
		checkFlagPath(seen, rows[r].f);
		stepAt(16'd12, NoStore);
		stepAt(16'd13, NoStore);
		stepAt(16'd14, secondStore);
		stepAt(16'd15, NoStore);
		stepAt(16'd16, NoStore);
		stepAt(16'd18, NoStore);
		stepAt(16'd18, NoStore);
	endtask

	initial begin
		logic [3:0] code;
		word_t a;
		word_t b;
		rst = 1'b1;
		fillNop();
		void'($urandom(9));
		rows[0] = makeRow(ADD, 16'h00F0, 16'h0023);
		rows[1] = makeRow(ADD, 16'h00FF, 16'h0001);
		rows[2] = makeRow(SUB, 16'h0005, 16'h0005);
		rows[3] = makeRow(SUB, 16'h0003, 16'h0007);
		rows[4] = makeRow(AND, 16'h005A, 16'h000F);
		rows[5] = makeRow(OR, 16'h00A0, 16'h0005);
		rows[6] = makeRow(XOR, 16'h003C, 16'h003C);
		rows[7] = makeRow(SHL, 16'h0081, 16'h0009);
		rows[8] = makeRow(SHR, 16'h0003, 16'h0001);
		rows[9] = makeRow(MOV, 16'h0077, 16'h0042);
		for (int i = FixedRows; i < NumRows; i++) begin
			code = 4'($urandom % 8);
			a = 16'($urandom % 256);
			b = 16'($urandom % 256);
			rows[i] = makeRow(opcode_e'(code), a, b);
		end
		for (int r = 0; r < NumRows; r++) begin
			runRow(r);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

/* vlog.f */
rtl/cpuPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/pcUnit.sv
rtl/loadStoreUnit.sv
rtl/cpuTop.sv
verification/cpuTop_properties.sv
verification/cpuTop_tb.sv
